/* verilog/stm_pkg.sv */
// Shared sizes, register map and packet encodings for the software trace module.
// Also holds the retire port, event, flit and response structs.
`default_nettype none

package stm_pkg;

  localparam int xlen           = 32;          // Core data width.
  localparam int flit_width     = 16;          // Debug flit width.
  localparam int event_id_width = 16;
  localparam int fifo_depth     = 4;
  localparam int fifo_ptr_width = $clog2(fifo_depth);
  localparam int flit_cnt_width = 3;           // Longest packet is 8 flits.

  localparam logic [15:0] marker_pattern = 16'h1500;  // Upper half of a marker insn.
  localparam logic [4:0]  trace_reg_addr = 5'd3;      // x3 is shadowed.

  // Register map.
  localparam logic [flit_width-1:0] reg_mod_type = 16'd0;
  localparam logic [flit_width-1:0] reg_version  = 16'd1;
  localparam logic [flit_width-1:0] reg_overflow = 16'd2;
  localparam logic [flit_width-1:0] reg_enable   = 16'd3;

  localparam logic [flit_width-1:0] stm_mod_type = 16'h0005;
  localparam logic [flit_width-1:0] stm_version  = 16'h0001;
  localparam logic [flit_width-1:0] host_addr    = 16'h0000;  // Event destination.

  typedef enum logic [15:0] {
    pkt_reg_read  = 16'h0000,
    pkt_reg_write = 16'h0001,
    pkt_reg_resp  = 16'h0002,
    pkt_write_ack = 16'h0003,
    pkt_event     = 16'h0004
  } pkt_type_e;

  typedef struct packed {
    logic [xlen-1:0] insn;
    logic [xlen-1:0] pc;
    logic            valid;   // Retire valid.
    logic [xlen-1:0] wdata;
    logic [4:0]      waddr;
    logic            we;      // Register file write.
  } trace_port_t;

  typedef struct packed {
    logic [event_id_width-1:0] id;
    logic [xlen-1:0]           value;   // Shadowed x3.
    logic [xlen-1:0]           tstamp;
  } trace_event_t;

  typedef struct packed {
    logic [flit_width-1:0] data;
    logic                  last;
  } dbg_flit_t;

  typedef struct packed {
    logic [flit_width-1:0] dest;
    pkt_type_e             kind;    // Response or write ack.
    logic [flit_width-1:0] rdata;
  } reg_resp_t;

  typedef enum logic [1:0] {pkt_idle, pkt_resp, pkt_evt} pkt_state_e;

  typedef enum logic [2:0] {
    req_dest, req_src, req_type, req_addr, req_data, req_drop
  } req_state_e;

endpackage

`default_nettype wire

/* verilog/stm_trace_snoop.sv */
// Retire port snooper: x3 shadow, marker detection and event timestamping.
`timescale 1ns/10ps
`default_nettype none

module stm_trace_snoop (
  input  logic                  clk,
  input  logic                  arst_n,
  input  stm_pkg::trace_port_t  trace,
  input  logic                  enable,
  output stm_pkg::trace_event_t evt,
  output logic                  evt_push
);
  import stm_pkg::*;

  logic [xlen-1:0] x3_shadow;
  logic [xlen-1:0] tstamp;
  logic            marker;

  // Valid retire, marker pattern in upper half, nonzero id.
  assign marker = enable && trace.valid &&
                  (trace.insn[31:16] == marker_pattern) &&
                  (trace.insn[event_id_width-1:0] != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      x3_shadow <= '0;
      tstamp    <= '0;
      evt_push  <= 1'b0;
    end else begin
      tstamp   <= tstamp + 1'b1;  // Cycles since reset.
      evt_push <= marker;          // Pushed one edge later.
      if (trace.valid && trace.we && (trace.waddr == trace_reg_addr)) begin
        x3_shadow <= trace.wdata;  // Same-cycle marker still sees old value.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (marker) begin
      evt.id     <= trace.insn[event_id_width-1:0];
      evt.value  <= x3_shadow;
      evt.tstamp <= tstamp;
    end
  end

  a_push_nonzero_id: assert property (@(posedge clk) disable iff (!arst_n)
    evt_push |-> (evt.id != '0));

endmodule

`default_nettype wire

/* verilog/stm_event_fifo.sv */
// Four-entry circular event queue.
// Pushes that find it full are dropped and counted, saturating.
`timescale 1ns/10ps
`default_nettype none

module stm_event_fifo (
  input  logic                          clk,
  input  logic                          arst_n,
  input  stm_pkg::trace_event_t         evt,
  input  logic                          evt_push,
  output stm_pkg::trace_event_t         evt_head,
  output logic                          evt_avail,
  input  logic                          evt_pop,
  output logic [stm_pkg::flit_width-1:0] overflow_cnt
);
  import stm_pkg::*;

  trace_event_t              mem [fifo_depth];
  logic [fifo_ptr_width-1:0] wr_ptr;
  logic [fifo_ptr_width-1:0] rd_ptr;
  logic [fifo_ptr_width:0]   count;
  logic                      full;
  logic                      do_push;
  logic                      do_pop;

  assign full      = (count == fifo_depth);
  assign evt_avail = (count != '0);
  assign evt_head  = mem[rd_ptr];
  assign do_push   = evt_push && !full;  // Full queue drops the push.
  assign do_pop    = evt_pop && evt_avail;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      overflow_cnt <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two.
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (evt_push && full && (overflow_cnt != '1)) begin
        overflow_cnt <= overflow_cnt + 1'b1;  // Saturates.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= evt;
  end

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
    evt_pop |-> evt_avail);

endmodule

`default_nettype wire

/* verilog/stm_reg_if.sv */
// Debug request parser and register file.
// Answers reads with a response and writes with an acknowledge.
`timescale 1ns/10ps
`default_nettype none

module stm_reg_if (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic [stm_pkg::flit_width-1:0] id,
  input  stm_pkg::dbg_flit_t             din,
  input  logic                           din_valid,
  output logic                           din_ready,
  input  logic [stm_pkg::flit_width-1:0] overflow_cnt,
  output logic                           enable,
  output stm_pkg::reg_resp_t             resp,
  output logic                           resp_valid,
  input  logic                           resp_taken
);
  import stm_pkg::*;

  req_state_e            state;
  logic                  hit;     // Request is addressed to us.
  logic [flit_width-1:0] src_q;
  logic [flit_width-1:0] addr_q;
  pkt_type_e             kind_q;
  logic [flit_width-1:0] rdata;
  logic                  accept;
  logic                  rd_done;
  logic                  wr_done;

  assign din_ready = !resp_valid;  // One request ahead at most.
  assign accept    = din_valid && din_ready;
  assign rd_done   = accept && (state == req_addr) && din.last && hit &&
                     (kind_q == pkt_reg_read);
  assign wr_done   = accept && (state == req_data) && hit && (kind_q == pkt_reg_write);

  // Read address is the flit being accepted.
  always_comb begin
    case (din.data)
      reg_mod_type: rdata = stm_mod_type;
      reg_version:  rdata = stm_version;
      reg_overflow: rdata = overflow_cnt;
      reg_enable:   rdata = {{(flit_width-1){1'b0}}, enable};
      default:      rdata = '0;  // Unknown address.
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= req_dest;
      resp_valid <= 1'b0;
      enable     <= 1'b1;
    end else begin
      if (resp_taken) resp_valid <= 1'b0;
      if (rd_done || wr_done) resp_valid <= 1'b1;
      if (wr_done && (addr_q == reg_enable)) enable <= din.data[0];  // Others read-only.
      if (accept) begin
        if (din.last) begin
          state <= req_dest;
        end else begin
          case (state)
            req_dest: state <= req_src;
            req_src:  state <= req_type;
            req_type: state <= req_addr;
            req_addr: state <= req_data;
            default:  state <= req_drop;  // Consume surplus flits.
          endcase
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      case (state)
        req_dest: hit    <= (din.data == id);
        req_src:  src_q  <= din.data;
        req_type: kind_q <= pkt_type_e'(din.data);
        req_addr: addr_q <= din.data;
        default:  ;
      endcase
    end
    if (rd_done) resp <= '{dest: src_q, kind: pkt_reg_resp, rdata: rdata};
    if (wr_done) resp <= '{dest: src_q, kind: pkt_write_ack, rdata: '0};
  end

endmodule

`default_nettype wire

/* verilog/stm_packetizer.sv */
// Output packetizer.
// Picks a register response or a queued event and sends it as flits.
`timescale 1ns/10ps
`default_nettype none

module stm_packetizer (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic [stm_pkg::flit_width-1:0] id,
  input  stm_pkg::reg_resp_t             resp,
  input  logic                           resp_valid,
  output logic                           resp_taken,
  input  stm_pkg::trace_event_t          evt_head,
  input  logic                           evt_avail,
  output logic                           evt_pop,
  output stm_pkg::dbg_flit_t             dout,
  output logic                           dout_valid,
  input  logic                           dout_ready
);
  import stm_pkg::*;

  pkt_state_e                state;
  logic [flit_cnt_width-1:0] cnt;       // Index of the next flit.
  logic [flit_cnt_width-1:0] flit_idx;
  logic                      use_evt;
  logic                      start;
  logic                      load;
  logic                      xfer_last;
  dbg_flit_t                 nxt;

  assign dout_valid = (state != pkt_idle);
  assign start      = (state == pkt_idle) && (resp_valid || evt_avail);
  assign load       = start || (dout_valid && dout_ready && !dout.last);
  assign xfer_last  = dout_valid && dout_ready && dout.last;
  assign resp_taken = xfer_last && (state == pkt_resp);
  assign evt_pop    = xfer_last && (state == pkt_evt);

  // Next flit content. Responses win when idle.
  always_comb begin
    flit_idx = (state == pkt_idle) ? '0 : cnt;
    use_evt  = (state == pkt_idle) ? !resp_valid : (state == pkt_evt);
    nxt      = '0;
    if (use_evt) begin
      case (flit_idx)
        3'd0: nxt.data = host_addr;
        3'd1: nxt.data = id;
        3'd2: nxt.data = pkt_event;
        3'd3: nxt.data = evt_head.tstamp[15:0];
        3'd4: nxt.data = evt_head.tstamp[31:16];
        3'd5: nxt.data = evt_head.id;
        3'd6: nxt.data = evt_head.value[15:0];
        default: begin
          nxt.data = evt_head.value[31:16];
          nxt.last = 1'b1;                              // Eighth flit.
        end
      endcase
    end else begin
      case (flit_idx)
        3'd0: nxt.data = resp.dest;                     // Back to requester.
        3'd1: nxt.data = id;
        3'd2: begin
          nxt.data = resp.kind;
          nxt.last = (resp.kind == pkt_write_ack);      // Ack has no data.
        end
        default: begin
          nxt.data = resp.rdata;
          nxt.last = 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= pkt_idle;
      cnt   <= '0;
    end else if (start) begin
      state <= resp_valid ? pkt_resp : pkt_evt;
      cnt   <= 3'd1;
    end else if (xfer_last) begin
      state <= pkt_idle;
    end else if (load) begin
      cnt <= cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load) dout <= nxt;
  end

  a_stall_stable: assert property (@(posedge clk) disable iff (!arst_n)
    dout_valid && !dout_ready |=> dout_valid && $stable(dout));

endmodule

`default_nettype wire

/* verilog/stm_top.sv */
// Software trace module top level.
// Snooper, event queue, register interface and packetizer.
`timescale 1ns/10ps
`default_nettype none

module stm_top (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic [stm_pkg::flit_width-1:0] id,
  input  stm_pkg::trace_port_t           trace,
  input  stm_pkg::dbg_flit_t             din,
  input  logic                           din_valid,
  output logic                           din_ready,
  output stm_pkg::dbg_flit_t             dout,
  output logic                           dout_valid,
  input  logic                           dout_ready
);
  import stm_pkg::*;

  logic                  enable;
  trace_event_t          evt;
  logic                  evt_push;
  trace_event_t          evt_head;
  logic                  evt_avail;
  logic                  evt_pop;
  logic [flit_width-1:0] overflow_cnt;
  reg_resp_t             resp;
  logic                  resp_valid;
  logic                  resp_taken;

  stm_trace_snoop snoop0 (
    .clk(clk), .arst_n(arst_n), .trace(trace), .enable(enable),
    .evt(evt), .evt_push(evt_push)
  );

  stm_event_fifo fifo0 (
    .clk(clk), .arst_n(arst_n), .evt(evt), .evt_push(evt_push),
    .evt_head(evt_head), .evt_avail(evt_avail), .evt_pop(evt_pop),
    .overflow_cnt(overflow_cnt)
  );

  stm_reg_if regs0 (
    .clk(clk), .arst_n(arst_n), .id(id), .din(din), .din_valid(din_valid),
    .din_ready(din_ready), .overflow_cnt(overflow_cnt), .enable(enable),
    .resp(resp), .resp_valid(resp_valid), .resp_taken(resp_taken)
  );

  stm_packetizer pkt0 (
    .clk(clk), .arst_n(arst_n), .id(id), .resp(resp), .resp_valid(resp_valid),
    .resp_taken(resp_taken), .evt_head(evt_head), .evt_avail(evt_avail),
    .evt_pop(evt_pop), .dout(dout), .dout_valid(dout_valid), .dout_ready(dout_ready)
  );

endmodule

`default_nettype wire

/* tb/stm_tb.sv */
// Testbench for the software trace module.
// Reads commands from the stim file, models x3 and enable, checks every output packet.
`timescale 1ns/10ps
`default_nettype none

module stm_tb;
  import stm_pkg::*;

  localparam logic [15:0] dut_id   = 16'h0023;
  localparam logic [15:0] req_src  = 16'h0009;  // Requester address.
  localparam int          wait_max = 2000;      // Cycles per wait.

  logic         clk;
  logic         arst_n;
  trace_port_t  trace;
  dbg_flit_t    din;
  logic         din_valid;
  logic         din_ready;
  dbg_flit_t    dout;
  logic         dout_valid;
  logic         dout_ready;

  logic [31:0]  stim [0:255];
  trace_event_t exp_evt [$];                    // Expected events, in order.
  reg_resp_t    exp_resp [$];                   // Expected responses, in order.
  logic [15:0]  pkt [0:7];
  integer       plen = 0;
  integer       seed = 25032;
  integer       err_cnt;
  integer       test_err0;
  integer       tests_run;
  integer       tests_failed;
  integer       held_cnt;                       // Markers seen while ready is held.
  logic [31:0]  x3_model;
  logic [31:0]  last_ts;
  logic         en_model;
  logic         have_ts;
  logic         hold_low;
  logic         timed_out;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  stm_top dut0 (
    .clk(clk), .arst_n(arst_n), .id(dut_id), .trace(trace), .din(din),
    .din_valid(din_valid), .din_ready(din_ready), .dout(dout),
    .dout_valid(dout_valid), .dout_ready(dout_ready)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_packet(input integer n);
    trace_event_t e;
    reg_resp_t    r;
    logic [31:0]  ts;
    case (pkt[2])
      pkt_event: begin
        check_value("event length", n, 8);
        check_value("event dest", pkt[0], host_addr);
        check_value("event src", pkt[1], dut_id);
        assert (exp_evt.size() > 0) else begin
          $display("Event packet arrived while none was expected");
          err_cnt++;
        end
        if (exp_evt.size() > 0) begin
          e = exp_evt.pop_front();
          check_value("event id", pkt[5], e.id);
          check_value("event value", {pkt[7], pkt[6]}, e.value);
        end
        ts = {pkt[4], pkt[3]};
        assert (!have_ts || ts > last_ts) else begin
          $display("Event timestamp %h did not increase past %h", ts, last_ts);
          err_cnt++;
        end
        last_ts = ts;
        have_ts = 1'b1;
      end
      pkt_reg_resp, pkt_write_ack: begin
        assert (exp_resp.size() > 0) else begin
          $display("Response packet arrived while none was expected");
          err_cnt++;
        end
        if (exp_resp.size() > 0) begin
          r = exp_resp.pop_front();
          check_value("resp kind", pkt[2], r.kind);
          check_value("resp length", n, (r.kind == pkt_write_ack) ? 3 : 4);
          check_value("resp dest", pkt[0], r.dest);
          check_value("resp src", pkt[1], dut_id);
          if (r.kind == pkt_reg_resp) check_value("resp rdata", pkt[3], r.rdata);
        end
      end
      default: begin
        $display("Packet with unknown type %h", pkt[2]);
        err_cnt++;
      end
    endcase
  endtask

  // Ready throttle and packet collector. Flits are taken where valid and ready meet.
  always @(negedge clk) begin
    dout_ready = hold_low ? 1'b0 : (($random(seed) & 3) != 0);
    if (arst_n && dout_valid && dout_ready) begin
      pkt[plen] = dout.data;
      plen = plen + 1;
      if (dout.last) begin
        check_packet(plen);
        plen = 0;
      end else begin
        assert (plen < 8) else begin
          $display("Packet ran past 8 flits without a last bit");
          err_cnt++;
          plen = 0;
        end
      end
    end
  end

  task automatic apply_trace(input logic [31:0] insn, input logic [31:0] ctl,
                             input logic [31:0] wdata);
    trace_event_t e;
    trace.insn  = insn;
    trace.valid = ctl[9];
    trace.we    = ctl[8];
    trace.waddr = ctl[4:0];
    trace.wdata = wdata;
    if (ctl[9] && insn[31:16] == marker_pattern && insn[15:0] != 16'h0 && en_model) begin
      e = '{id: insn[15:0], value: x3_model, tstamp: 32'h0};  // Old x3 value.
      if (!hold_low || held_cnt < fifo_depth) exp_evt.push_back(e);
      held_cnt++;
    end
    if (ctl[9] && ctl[8] && ctl[4:0] == 5'd3) x3_model = wdata;
    @(negedge clk);
    trace.valid = 1'b0;
  endtask

  task automatic send_request(input logic [15:0] dest, input logic [15:0] kind,
                              input logic [15:0] addr, input logic [15:0] data);
    logic [15:0] flits [0:4];
    integer      n;
    integer      i;
    integer      t;
    flits[0] = dest;
    flits[1] = req_src;
    flits[2] = kind;
    flits[3] = addr;
    flits[4] = data;
    n = (kind == pkt_reg_write) ? 5 : 4;
    for (i = 0; i < n; i++) begin
      din.data  = flits[i];
      din.last  = (i == n - 1);
      din_valid = 1'b1;
      t = 0;
      while (!din_ready && t < wait_max) begin
        @(negedge clk);
        t++;
      end
      if (!din_ready) begin
        $display("Timed out waiting for din_ready on request flit %0d", i);
        timed_out = 1'b1;
        din_valid = 1'b0;
        return;
      end
      @(negedge clk);                           // Accepted at the rising edge.
    end
    din_valid = 1'b0;
  endtask

  task automatic finish_test(input integer num);
    integer t;
    t = 0;
    while ((exp_evt.size() != 0 || exp_resp.size() != 0) && t < wait_max) begin
      @(negedge clk);
      t++;
    end
    if (exp_evt.size() != 0 || exp_resp.size() != 0) begin
      $display("Timed out with %0d events and %0d responses still missing",
               exp_evt.size(), exp_resp.size());
      timed_out = 1'b1;
    end
    for (t = 0; t < 40; t++) @(negedge clk);  // Window for stray packets.
    tests_run++;
    if (err_cnt != test_err0 || timed_out) begin
      tests_failed++;
      $display("test %0d: %0d errors", num, err_cnt - test_err0);
    end else begin
      $display("test %0d: ok", num);
    end
    test_err0 = err_cnt;
  endtask

  initial begin
    integer      idx;
    logic [31:0] op;
    arst_n     = 1'b0;
    trace      = '0;
    din        = '0;
    din_valid  = 1'b0;
    dout_ready = 1'b0;
    x3_model   = '0;
    last_ts    = '0;
    en_model   = 1'b1;                          // Enable resets to 1.
    have_ts    = 1'b0;
    hold_low   = 1'b0;
    timed_out  = 1'b0;
    held_cnt   = 0;
    err_cnt    = 0;
    test_err0  = 0;
    tests_run  = 0;
    tests_failed = 0;
    $readmemh("tb/stm_stim.txt", stim);
    repeat (2) @(negedge clk);
    check_value("din_ready", din_ready, 32'h1);     // Reset state.
    check_value("dout_valid", dout_valid, 32'h0);
    arst_n = 1'b1;
    idx = 0;
    while (idx < 252 && stim[idx] != 32'h0 && !timed_out) begin
      op = stim[idx];
      case (op)
        1: apply_trace(stim[idx+1], stim[idx+2], stim[idx+3]);
        2: begin
          if (stim[idx+1][15:0] == dut_id)
            exp_resp.push_back('{dest: req_src, kind: pkt_reg_resp, rdata: stim[idx+3][15:0]});
          send_request(stim[idx+1][15:0], pkt_reg_read, stim[idx+2][15:0], 16'h0);
        end
        3: begin
          if (stim[idx+1][15:0] == dut_id) begin
            exp_resp.push_back('{dest: req_src, kind: pkt_write_ack, rdata: 16'h0});
            if (stim[idx+2][15:0] == reg_enable) en_model = stim[idx+3][0];
          end
          send_request(stim[idx+1][15:0], pkt_reg_write, stim[idx+2][15:0],
                       stim[idx+3][15:0]);
        end
        4: begin
          hold_low = stim[idx+1][0];
          held_cnt = 0;
        end
        5: finish_test(stim[idx+1]);
        default: begin
          $display("Unknown stim command %h at record %0d", op, idx / 4);
          err_cnt++;
        end
      endcase
      idx += 4;
    end
    $display("tests: %0d run, %0d with errors, %0d checks failed",
             tests_run, tests_failed, err_cnt);
    if (err_cnt == 0 && !timed_out && tests_run > 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/stm_stim.txt */
// Records of four hex words: op a b c. op 1 trace: a insn, b {valid[9],we[8],waddr}, c wdata.
// op 2 read: a dest, b addr, c expected data. op 3 write: a dest, b addr, c data.
// op 4 ready hold: a 1 holds dout_ready low, 0 throttles it. op 5 ends test a. op 0 stops.
1 00000093 303 CAFE0001
1 15000007 200 0
1 00000013 303 12345678
1 15000008 200 0
5 1 0 0
1 15000000 200 0
1 15000009 000 0
1 14000009 200 0
1 1500000A 303 0BADF00D
1 1500000B 200 0
5 2 0 0
2 0023 0 0005
2 0023 1 0001
2 0044 0 0005
5 3 0 0
3 0023 3 0
1 1500000C 200 0
3 0023 3 1
1 1500000D 200 0
2 0023 3 0001
5 4 0 0
4 1 0 0
1 15000011 200 0
1 15000012 200 0
1 15000013 200 0
1 15000014 200 0
1 15000015 200 0
1 15000016 200 0
4 0 0 0
2 0023 2 0002
5 5 0 0
1 00000193 303 A5A5A5A5
1 15000031 200 0
2 0023 1 0001
1 15000032 200 0
3 0023 0 1234
2 0023 0 0005
5 6 0 0
0 0 0 0

/* project.f */
verilog/stm_pkg.sv
verilog/stm_trace_snoop.sv
verilog/stm_event_fifo.sv
verilog/stm_reg_if.sv
verilog/stm_packetizer.sv
verilog/stm_top.sv
tb/stm_tb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module stm_tb -o stm_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/stm_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Test completed successfully"; then
  exit 0
fi
exit 1
